// File: tb.f
rtl/ethcap_pkg.sv
rtl/gmii_rx_writer.sv
rtl/slot_ram.sv
rtl/host_regs.sv
rtl/ethcap_top.sv
tests/ethcap_assert.sv
tests/tb_ethcap.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_ethcap \
  -o tb_ethcap

./obj_dir/tb_ethcap

// File: tests/tb_ethcap.sv
`default_nettype none

module tb_ethcap;

  localparam int MAX_LEN   = 300;
  localparam int NUM_CASES = 6;
  localparam ethcap_pkg::host_addr_t SLOT_BASE = {ethcap_pkg::REGION_SLOT, 13'h0000};

  typedef struct {
    string name;
    int    len;
    bit    while_full;
    int    exp_len;
  } frame_case_t;

  logic                  clk_125 = 1'b0;
  logic                  core_rst_n;
  ethcap_pkg::gmii_rx_t  gmii;
  ethcap_pkg::host_req_t host_req;
  ethcap_pkg::host_rsp_t host_rsp;
  logic                  irq;

  frame_case_t           frame_tab [NUM_CASES];
  logic [7:0]            frame_bytes [MAX_LEN];
  logic [7:0]            held_bytes [MAX_LEN];
  int                    held_len;
  ethcap_pkg::tstamp_t   prev_ts;

  ethcap_top dut (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .gmii_i     (gmii),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .irq_o      (irq)
  );

  always #5 clk_125 = ~clk_125;

  // ------------------------------------------------------------------
  // error reporting
  // ------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    stop_on_error($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  // ------------------------------------------------------------------
  // host bus
  // ------------------------------------------------------------------
  task automatic bus_access(input ethcap_pkg::host_addr_t addr, input logic we,
                            input logic [1:0] sel, input ethcap_pkg::host_data_t wdat,
                            output ethcap_pkg::host_data_t rdat);
    int cycles;
    cycles = 0;
    @(posedge clk_125);
    #1;
    host_req = '{adr: addr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    while (!host_rsp.ack) begin
      if (cycles == 20) begin
        stop_on_error($sformatf("no ack on the host bus for address 0x%04h", addr));
      end
      @(posedge clk_125);
      #1;
      cycles++;
    end
    rdat = host_rsp.dat;
    // strobe held through the ack cycle
    @(posedge clk_125);
    #1;
    host_req = '0;
  endtask

  task automatic bus_read(input ethcap_pkg::host_addr_t addr,
                          output ethcap_pkg::host_data_t rdat);
    bus_access(addr, 1'b0, 2'b11, '0, rdat);
  endtask

  task automatic bus_write(input ethcap_pkg::host_addr_t addr, input logic [1:0] sel,
                           input ethcap_pkg::host_data_t wdat);
    ethcap_pkg::host_data_t ignored;
    bus_access(addr, 1'b1, sel, wdat, ignored);
  endtask

  // low half first, upper halves do not move meanwhile
  task automatic read_wide(input ethcap_pkg::host_addr_t base,
                           output ethcap_pkg::tstamp_t value);
    ethcap_pkg::host_data_t half;
    value = '0;
    for (int k = 0; k < 4; k++) begin
      bus_read(base + 16'(2 * k), half);
      value[16 * k +: 16] = half;
    end
  endtask

  task automatic check_unmapped(input ethcap_pkg::host_addr_t addr);
    ethcap_pkg::host_data_t rd;
    bus_write(addr, 2'b11, 16'hFFFF);
    bus_read(addr, rd);
    assert (rd == 16'h0000)
      else report_mismatch($sformatf("unmapped_%04h", addr), 64'h0, 64'(rd));
  endtask

  // ------------------------------------------------------------------
  // GMII side and slot handling
  // ------------------------------------------------------------------
  task automatic wait_irq(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (irq !== level) begin
      if (cycles == limit) begin
        stop_on_error($sformatf("irq_o did not go to %0b within %0d cycles %s",
                                level, limit, what));
      end
      @(posedge clk_125);
      #1;
      cycles++;
    end
  endtask

  task automatic send_frame(input int n);
    // inter-frame gap
    repeat (12) @(posedge clk_125);
    #1;
    gmii.dv = 1'b1;
    for (int i = 0; i < n; i++) begin
      gmii.rxd = frame_bytes[i];
      @(posedge clk_125);
      #1;
    end
    gmii = '0;
  endtask

  task automatic release_slot(input string name);
    ethcap_pkg::host_data_t rd;
    if (irq) begin
      bus_write(ethcap_pkg::ADDR_STATUS, 2'b01, 16'h0001);
      wait_irq(1'b0, 10, {"after clearing the slot at ", name});
      bus_read(ethcap_pkg::ADDR_STATUS, rd);
      assert (rd == 16'h0000) else report_mismatch({name, "_status"}, 64'h0, 64'(rd));
    end
  endtask

  // little-endian words, bytes past the frame end masked off
  task automatic check_slot(input string name);
    ethcap_pkg::slot_word_t exp_w;
    ethcap_pkg::slot_word_t mask_w;
    ethcap_pkg::host_data_t lo;
    ethcap_pkg::host_data_t hi;
    for (int w = 0; w < (held_len + 3) / 4; w++) begin
      exp_w  = '0;
      mask_w = '0;
      for (int b = 0; b < 4; b++) begin
        if (4 * w + b < held_len) begin
          exp_w[8 * b +: 8]  = held_bytes[4 * w + b];
          mask_w[8 * b +: 8] = 8'hFF;
        end
      end
      bus_read(SLOT_BASE + 16'(4 * w), lo);
      bus_read(SLOT_BASE + 16'(4 * w + 2), hi);
      assert (({hi, lo} & mask_w) == (exp_w & mask_w))
        else report_mismatch($sformatf("%s_word%0d", name, w), 64'(exp_w & mask_w),
                             64'({hi, lo} & mask_w));
    end
  endtask

  task automatic fill_payload(input int n);
    for (int i = 0; i < n; i++) begin
      frame_bytes[i] = 8'($urandom);
    end
  endtask

  task automatic run_capture(input int c);
    ethcap_pkg::tstamp_t    cnt_before;
    ethcap_pkg::tstamp_t    ts;
    ethcap_pkg::host_data_t len;
    string                  name;
    name = frame_tab[c].name;
    release_slot(name);
    fill_payload(frame_tab[c].len);
    read_wide(ethcap_pkg::ADDR_CNT0, cnt_before);
    send_frame(frame_tab[c].len);
    wait_irq(1'b1, 20, {"after frame ", name});
    bus_read(ethcap_pkg::ADDR_LEN, len);
    assert (len == 16'(frame_tab[c].exp_len))
      else report_mismatch({name, "_len"}, 64'(frame_tab[c].exp_len), 64'(len));
    read_wide(ethcap_pkg::ADDR_TS0, ts);
    assert (ts > prev_ts)
      else stop_on_error({"timestamp did not increase at frame ", name});
    assert (ts >= cnt_before && ts - cnt_before < 64'd100)
      else stop_on_error({"timestamp too far from the counter read at frame ", name});
    prev_ts  = ts;
    held_len = frame_tab[c].len;
    for (int i = 0; i < held_len; i++) begin
      held_bytes[i] = frame_bytes[i];
    end
    check_slot(name);
  endtask

  // slot still owned by the host, the new frame must vanish
  task automatic run_drop(input int c);
    ethcap_pkg::host_data_t len;
    string                  name;
    name = frame_tab[c].name;
    assert (irq == 1'b1) else stop_on_error({"no frame held before ", name});
    fill_payload(frame_tab[c].len);
    send_frame(frame_tab[c].len);
    repeat (4) @(posedge clk_125);
    #1;
    assert (irq == 1'b1) else stop_on_error({"irq_o dropped during ", name});
    bus_read(ethcap_pkg::ADDR_LEN, len);
    assert (len == 16'(frame_tab[c].exp_len))
      else report_mismatch({name, "_len"}, 64'(frame_tab[c].exp_len), 64'(len));
    check_slot(name);
  endtask

  task automatic add_case(input int idx, input string name, input int len,
                          input bit while_full, input int exp_len);
    frame_tab[idx].name       = name;
    frame_tab[idx].len        = len;
    frame_tab[idx].while_full = while_full;
    frame_tab[idx].exp_len    = exp_len;
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    ethcap_pkg::host_data_t rd;
    ethcap_pkg::tstamp_t    cnt_val;
    ethcap_pkg::tstamp_t    cnt_rd;
    void'($urandom(16870));
    core_rst_n = 1'b0;
    gmii       = '0;
    host_req   = '0;
    prev_ts    = '0;
    held_len   = 0;
    add_case(0, "one_byte", 1, 1'b0, 1);
    add_case(1, "one_word", 4, 1'b0, 4);
    add_case(2, "word_plus_one", 5, 1'b0, 5);
    add_case(3, "drop_while_full", 63, 1'b1, 5);
    add_case(4, "after_drop", 63, 1'b0, 63);
    add_case(5, "long_frame", 300, 1'b0, 300);
    repeat (8) @(posedge clk_125);
    #1;
    core_rst_n = 1'b1;

    assert (irq == 1'b0) else report_mismatch("reset_irq", 64'h0, 64'(irq));
    bus_read(ethcap_pkg::ADDR_STATUS, rd);
    assert (rd == 16'h0000) else report_mismatch("reset_status", 64'h0, 64'(rd));
    check_unmapped(16'h2000);
    check_unmapped(16'h0010);
    check_unmapped(16'h8010);
    check_unmapped(16'hC000);
    check_unmapped(16'hE000);

    // counter keeps running between the half writes
    cnt_val = 64'h1234_5678_9ABC_1000;
    for (int k = 0; k < 4; k++) begin
      bus_write(ethcap_pkg::ADDR_CNT0 + 16'(2 * k), 2'b11, cnt_val[16 * k +: 16]);
    end
    read_wide(ethcap_pkg::ADDR_CNT0, cnt_rd);
    assert (cnt_rd >= cnt_val && cnt_rd - cnt_val < 64'd100)
      else stop_on_error($sformatf("counter read 0x%0h out of range of 0x%0h", cnt_rd, cnt_val));
    bus_write(ethcap_pkg::ADDR_CNT0 + 16'd6, 2'b01, 16'hA5C3);
    bus_read(ethcap_pkg::ADDR_CNT0 + 16'd6, rd);
    assert (rd == {cnt_val[63:56], 8'hC3})
      else report_mismatch("cnt_low_lane", 64'({cnt_val[63:56], 8'hC3}), 64'(rd));
    bus_read(ethcap_pkg::ADDR_CNT0 + 16'd4, rd);
    assert (rd == cnt_val[47:32])
      else report_mismatch("cnt_other_half", 64'(cnt_val[47:32]), 64'(rd));

    for (int c = 0; c < NUM_CASES; c++) begin
      if (frame_tab[c].while_full) begin
        run_drop(c);
      end else begin
        run_capture(c);
      end
    end
    release_slot("end_of_run");

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/ethcap_assert.sv
`default_nettype none

module ethcap_assert (
  input wire logic clk_125,
  input wire logic core_rst_n,
  input wire logic stb_i,
  input wire logic cyc_i,
  input wire logic ack_i,
  input wire logic slot_req_i,
  input wire logic slot_ack_i
);

  // ------------------------------------------------------------------
  // host bus
  // ------------------------------------------------------------------
  ack_with_strobe: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    $rose(ack_i) |-> (stb_i && cyc_i))
    else $error("host ack rose without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    ack_i |=> !ack_i)
    else $error("host ack held longer than one cycle");

  // ------------------------------------------------------------------
  // slot hand-over
  // ------------------------------------------------------------------
  slot_ack_after_req: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    $rose(slot_ack_i) |-> slot_req_i)
    else $error("slot ack rose without slot req");

  slot_req_held: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    $fell(slot_req_i) |-> slot_ack_i)
    else $error("slot req fell before slot ack");

endmodule

bind host_regs ethcap_assert u_regs_assert (
  .clk_125    (clk_125),
  .core_rst_n (core_rst_n),
  .stb_i      (host_req_i.stb),
  .cyc_i      (host_req_i.cyc),
  .ack_i      (host_rsp_o.ack),
  .slot_req_i (slot_req_i),
  .slot_ack_i (slot_ack_o)
);

`default_nettype wire

// File: rtl/ethcap_top.sv
`default_nettype none

module ethcap_top (
  input  wire logic                  clk_125,
  input  wire logic                  core_rst_n,
  input  wire ethcap_pkg::gmii_rx_t  gmii_i,
  input  wire ethcap_pkg::host_req_t host_req_i,
  output ethcap_pkg::host_rsp_t      host_rsp_o,
  output logic                       irq_o
);

  ethcap_pkg::slot_wr_t    slot_wr;
  ethcap_pkg::frame_info_t info;
  ethcap_pkg::tstamp_t     counter;
  ethcap_pkg::slot_addr_t  rd_addr;
  ethcap_pkg::slot_word_t  rd_data;
  logic                    slot_req;
  logic                    slot_ack;

  // receive side
  gmii_rx_writer u_writer (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .gmii_i     (gmii_i),
    .counter_i  (counter),
    .slot_ack_i (slot_ack),
    .slot_wr_o  (slot_wr),
    .info_o     (info),
    .slot_req_o (slot_req)
  );

  slot_ram u_ram (
    .clk_125   (clk_125),
    .wr_i      (slot_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  // host side
  host_regs u_regs (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .info_i     (info),
    .slot_req_i (slot_req),
    .slot_ack_o (slot_ack),
    .counter_o  (counter),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

// File: rtl/host_regs.sv
`default_nettype none

module host_regs (
  input  wire logic                    clk_125,
  input  wire logic                    core_rst_n,
  input  wire ethcap_pkg::host_req_t   host_req_i,
  output ethcap_pkg::host_rsp_t        host_rsp_o,
  input  wire ethcap_pkg::frame_info_t info_i,
  input  wire logic                    slot_req_i,
  output logic                         slot_ack_o,
  output ethcap_pkg::tstamp_t          counter_o,
  output ethcap_pkg::slot_addr_t       rd_addr_o,
  input  wire ethcap_pkg::slot_word_t  rd_data_i,
  output logic                         irq_o
);

  logic [2:0]             region_w;
  logic                   access_w;
  logic                   rd_w;
  logic                   wr_w;
  logic                   slot_rd_w;
  logic                   status_hit_w;
  logic                   cnt_hit_w;
  logic                   ts_hit_w;
  logic                   len_hit_w;
  logic                   pending_w;
  ethcap_pkg::host_addr_t cnt_off_w;
  ethcap_pkg::host_addr_t ts_off_w;
  ethcap_pkg::host_data_t reg_rd_w;
  ethcap_pkg::tstamp_t    counter_nx;
  ethcap_pkg::tstamp_t    counter_q;
  ethcap_pkg::host_data_t dat_q;
  ethcap_pkg::slot_addr_t rd_addr_q;
  logic                   ack_q;
  logic [1:0]             wait_q;
  logic                   slot_ack_q;

  // ------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------
  assign region_w  = host_req_i.adr[15:13];
  assign access_w  = host_req_i.cyc && host_req_i.stb && !ack_q;
  assign rd_w      = access_w && !host_req_i.we;
  assign wr_w      = access_w && host_req_i.we;
  assign slot_rd_w = rd_w && (region_w == ethcap_pkg::REGION_SLOT);

  assign cnt_off_w    = host_req_i.adr - ethcap_pkg::ADDR_CNT0;
  assign ts_off_w     = host_req_i.adr - ethcap_pkg::ADDR_TS0;
  assign status_hit_w = host_req_i.adr[15:1] == ethcap_pkg::ADDR_STATUS[15:1];
  assign cnt_hit_w    = cnt_off_w[15:3] == '0;
  assign ts_hit_w     = ts_off_w[15:3] == '0;
  assign len_hit_w    = host_req_i.adr[15:1] == ethcap_pkg::ADDR_LEN[15:1];

  // frame waiting for the host
  assign pending_w = slot_req_i && !slot_ack_q;

  always_comb begin
    reg_rd_w = '0;
    case (region_w)
      ethcap_pkg::REGION_GLOBAL: begin
        if (status_hit_w) begin
          reg_rd_w = {15'b0, pending_w};
        end else if (cnt_hit_w) begin
          reg_rd_w = counter_q[{cnt_off_w[2:1], 4'b0000} +: 16];
        end
      end
      ethcap_pkg::REGION_RX: begin
        if (ts_hit_w) begin
          reg_rd_w = info_i.ts[{ts_off_w[2:1], 4'b0000} +: 16];
        end else if (len_hit_w) begin
          reg_rd_w = ethcap_pkg::host_data_t'(info_i.len);
        end
      end
      default: reg_rd_w = '0;
    endcase
  end

  // free-running counter, host may overwrite any byte
  always_comb begin
    counter_nx = counter_q + 1'b1;
    if (wr_w && cnt_hit_w) begin
      if (host_req_i.sel[1]) begin
        counter_nx[{cnt_off_w[2:1], 4'b1000} +: 8] = host_req_i.dat[15:8];
      end
      if (host_req_i.sel[0]) begin
        counter_nx[{cnt_off_w[2:1], 4'b0000} +: 8] = host_req_i.dat[7:0];
      end
    end
  end

  // ------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      counter_q  <= '0;
      ack_q      <= 1'b0;
      wait_q     <= 2'd0;
      slot_ack_q <= 1'b0;
    end else begin
      counter_q <= counter_nx;
      ack_q     <= 1'b0;
      if (access_w) begin
        // slot reads: address, ram, data register
        if (slot_rd_w) begin
          if (wait_q == 2'd2) begin
            ack_q  <= 1'b1;
            wait_q <= 2'd0;
          end else begin
            wait_q <= wait_q + 2'd1;
          end
        end else begin
          ack_q <= 1'b1;
        end
      end
      // writing 1 to status bit 0 takes the slot
      if (wr_w && status_hit_w && host_req_i.sel[0] && host_req_i.dat[0] && slot_req_i) begin
        slot_ack_q <= 1'b1;
      end else if (slot_ack_q && !slot_req_i) begin
        slot_ack_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (slot_rd_w) begin
      rd_addr_q <= host_req_i.adr[12:2];
    end
    if (rd_w) begin
      if (!slot_rd_w) begin
        dat_q <= reg_rd_w;
      end else if (wait_q == 2'd2) begin
        dat_q <= host_req_i.adr[1] ? rd_data_i[31:16] : rd_data_i[15:0];
      end
    end
  end

  assign host_rsp_o = '{dat: dat_q, ack: ack_q};
  assign slot_ack_o = slot_ack_q;
  assign counter_o  = counter_q;
  assign rd_addr_o  = rd_addr_q;
  assign irq_o      = pending_w;

endmodule

`default_nettype wire

// File: rtl/slot_ram.sv
`default_nettype none

module slot_ram (
  input  wire logic                   clk_125,
  input  wire ethcap_pkg::slot_wr_t   wr_i,
  input  wire ethcap_pkg::slot_addr_t rd_addr_i,
  output ethcap_pkg::slot_word_t      rd_data_o
);

  ethcap_pkg::slot_word_t mem_q [0:(2**ethcap_pkg::SLOT_AW)-1];

  // write port, one enable per byte lane
  always_ff @(posedge clk_125) begin
    if (wr_i.en) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_i.be[i]) begin
          mem_q[wr_i.addr][8*i +: 8] <= wr_i.data[8*i +: 8];
        end
      end
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_125) begin
    rd_data_o <= mem_q[rd_addr_i];
  end

endmodule

`default_nettype wire

// File: rtl/gmii_rx_writer.sv
`default_nettype none

module gmii_rx_writer (
  input  wire logic                   clk_125,
  input  wire logic                   core_rst_n,
  input  wire ethcap_pkg::gmii_rx_t   gmii_i,
  input  wire ethcap_pkg::tstamp_t    counter_i,
  input  wire logic                   slot_ack_i,
  output ethcap_pkg::slot_wr_t        slot_wr_o,
  output ethcap_pkg::frame_info_t     info_o,
  output logic                        slot_req_o
);

  ethcap_pkg::rx_state_e  state_q;
  logic [1:0]             lane_q;
  logic [1:0]             lane_w;
  ethcap_pkg::frame_len_t len_q;
  ethcap_pkg::slot_addr_t ptr_q;
  logic                   full_q;
  logic                   wr_en_q;
  logic                   slot_req_q;
  ethcap_pkg::slot_word_t word_q;
  ethcap_pkg::slot_word_t wr_data_q;
  ethcap_pkg::byte_en_t   wr_be_q;
  ethcap_pkg::slot_addr_t wr_addr_q;
  ethcap_pkg::tstamp_t    ts_q;
  logic                   start_w;
  logic                   take_w;
  logic                   word_done_w;
  logic                   flush_w;

  // start only once the slot is back on the receive side
  assign start_w = (state_q == ethcap_pkg::IDLE) && gmii_i.dv && !slot_req_q && !slot_ack_i;
  assign take_w = start_w || ((state_q == ethcap_pkg::CAPTURE) && gmii_i.dv);
  assign lane_w = start_w ? 2'd0 : lane_q;
  assign word_done_w = take_w && (lane_w == 2'd3);
  assign flush_w = (state_q == ethcap_pkg::CAPTURE) && !gmii_i.dv && (lane_q != 2'd0);

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q    <= ethcap_pkg::IDLE;
      lane_q     <= 2'd0;
      len_q      <= '0;
      ptr_q      <= '0;
      full_q     <= 1'b0;
      wr_en_q    <= 1'b0;
      slot_req_q <= 1'b0;
    end else begin
      wr_en_q <= (word_done_w || flush_w) && !full_q;
      if (take_w) begin
        lane_q <= lane_w + 2'd1;
      end
      // length keeps counting past the end of the slot, up to 4095
      if (start_w) begin
        len_q  <= ethcap_pkg::frame_len_t'(1);
        ptr_q  <= '0;
        full_q <= 1'b0;
      end else if (take_w && (len_q != '1)) begin
        len_q <= len_q + 1'b1;
      end
      if (word_done_w && !full_q) begin
        ptr_q <= ptr_q + 1'b1;
        if (ptr_q == '1) begin
          full_q <= 1'b1;
        end
      end
      if (slot_req_q && slot_ack_i) begin
        slot_req_q <= 1'b0;
      end
      case (state_q)
        ethcap_pkg::IDLE: begin
          if (gmii_i.dv) begin
            state_q <= start_w ? ethcap_pkg::CAPTURE : ethcap_pkg::DISCARD;
          end
        end
        ethcap_pkg::CAPTURE: begin
          if (!gmii_i.dv) begin
            state_q <= ethcap_pkg::FLUSH;
          end
        end
        ethcap_pkg::FLUSH: begin
          state_q    <= ethcap_pkg::OFFER;
          slot_req_q <= 1'b1;
        end
        ethcap_pkg::OFFER: begin
          if (gmii_i.dv) begin
            state_q <= ethcap_pkg::DISCARD;
          end else if (!slot_req_q && !slot_ack_i) begin
            state_q <= ethcap_pkg::IDLE;
          end
        end
        ethcap_pkg::DISCARD: begin
          if (!gmii_i.dv) begin
            state_q <= ethcap_pkg::IDLE;
          end
        end
        default: state_q <= ethcap_pkg::IDLE;
      endcase
    end
  end

  // byte 0 lands in bits 7:0
  always_ff @(posedge clk_125) begin
    if (take_w) begin
      word_q[{lane_w, 3'b000} +: 8] <= gmii_i.rxd;
    end
    if (start_w) begin
      ts_q <= counter_i;
    end
    if (word_done_w) begin
      wr_data_q <= {gmii_i.rxd, word_q[23:0]};
      wr_be_q   <= 4'hF;
      wr_addr_q <= ptr_q;
    end else if (flush_w) begin
      wr_data_q <= word_q;
      wr_be_q   <= {1'b0, lane_q == 2'd3, lane_q[1], 1'b1};
      wr_addr_q <= ptr_q;
    end
  end

  assign slot_wr_o  = '{en: wr_en_q, addr: wr_addr_q, be: wr_be_q, data: wr_data_q};
  assign info_o     = '{len: len_q, ts: ts_q};
  assign slot_req_o = slot_req_q;

endmodule

`default_nettype wire

// File: rtl/ethcap_pkg.sv
`default_nettype none

package ethcap_pkg;

  // ------------------------------------------------------------------
  // widths and address map
  // ------------------------------------------------------------------
  localparam int HOST_DW = 16;
  localparam int HOST_AW = 16;
  localparam int SLOT_AW = 11;
  localparam int LEN_W   = 12;
  localparam int TS_W    = 64;

  // host address bits 15:13
  localparam logic [2:0] REGION_GLOBAL = 3'd0;
  localparam logic [2:0] REGION_RX     = 3'd4;
  localparam logic [2:0] REGION_SLOT   = 3'd5;

  localparam logic [HOST_AW-1:0] ADDR_STATUS = 16'h0000;
  localparam logic [HOST_AW-1:0] ADDR_CNT0   = 16'h0004;
  localparam logic [HOST_AW-1:0] ADDR_TS0    = 16'h8000;
  localparam logic [HOST_AW-1:0] ADDR_LEN    = 16'h800C;

  typedef logic [HOST_DW-1:0] host_data_t;
  typedef logic [HOST_AW-1:0] host_addr_t;
  typedef logic [SLOT_AW-1:0] slot_addr_t;
  typedef logic [31:0]        slot_word_t;
  typedef logic [3:0]         byte_en_t;
  typedef logic [LEN_W-1:0]   frame_len_t;
  typedef logic [TS_W-1:0]    tstamp_t;
  typedef logic [7:0]         gmii_byte_t;

  // ------------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------------
  typedef struct packed {
    host_addr_t adr;
    host_data_t dat;
    logic [1:0] sel;
    logic       we;
    logic       cyc;
    logic       stb;
  } host_req_t;

  typedef struct packed {
    host_data_t dat;
    logic       ack;
  } host_rsp_t;

  typedef struct packed {
    logic       dv;
    gmii_byte_t rxd;
  } gmii_rx_t;

  typedef struct packed {
    logic       en;
    slot_addr_t addr;
    byte_en_t   be;
    slot_word_t data;
  } slot_wr_t;

  typedef struct packed {
    frame_len_t len;
    tstamp_t    ts;
  } frame_info_t;

  typedef enum logic [2:0] {
    IDLE,
    CAPTURE,
    FLUSH,
    OFFER,
    DISCARD
  } rx_state_e;

endpackage

`default_nettype wire
